//--- ilk_tx_burst_top.f
ilk_pkg.sv
ilk_stream_if.sv
ilk_ready_skid.sv
ilk_burst_framer.sv
ilk_apb_regs.sv
ilk_tx_burst_top.sv
tb_ilk_tx_burst.sv

//--- Bender.yml
package:
  name: ilk_tx_burst

sources:
  - ilk_pkg.sv
  - ilk_stream_if.sv
  - ilk_ready_skid.sv
  - ilk_burst_framer.sv
  - ilk_apb_regs.sv
  - ilk_tx_burst_top.sv
  - target: test
    files:
      - tb_ilk_tx_burst.sv

//--- tb_ilk_tx_burst.sv
/*
 * Interlaken TX burst path testbench
 * directed tests over APB config, packet framing and back-pressure,
 * output checked against a framing model built from the burst rules
 */
`timescale 1ns/10ps

module tb_ilk_tx_burst;
	import ilk_pkg::*;

	localparam int CLK_HALF   = 5;
	localparam int WAIT_LIMIT = 200;
	localparam int QUIET      = 20;

	logic        clk;
	logic        arst;
	logic        psel_i;
	logic        penable_i;
	logic        pwrite_i;
	logic [7:0]  paddr_i;
	logic [31:0] pwdata_i;
	logic [31:0] prdata_o;
	logic        pready_o;
	logic        pslverr_o;
	logic        in_valid_i;
	logic        in_ready_o;
	logic [63:0] in_data_i;
	logic        in_sop_i;
	logic        in_eop_i;
	logic [2:0]  in_eop_bytes_i;
	logic        out_valid_o;
	logic        out_ready_i;
	logic [63:0] out_data_o;
	logic        out_ctrl_o;
	logic        out_sop_o;
	logic        out_eop_o;

	logic [31:0] seed;
	int          errors;
	int          checks;
	int          tests;
	int          test_err0;
	int          bmax;
	logic [7:0]  chan_cfg;
	int          data_total;
	int          ctrl_total;

	// stimulus words, flags per word are {sop, eop}
	logic [63:0] stim_data[$];
	logic [1:0]  stim_flags[$];
	logic [2:0]  stim_bytes[$];
	// expected and collected output, flags are {ctrl, sop, eop}
	ilk_word_u   exp_word[$];
	logic [2:0]  exp_flags[$];
	ilk_word_u   got_word[$];
	logic [2:0]  got_flags[$];

	ilk_tx_burst_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	function automatic logic [31:0] rand32();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic report_fail(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic check_word(input ilk_word_u got, input ilk_word_u exp, input string what);
		checks++;
		if (got.data !== exp.data) begin
			$display("MISMATCH at %0t: %s word got %h expected %h", $time, what, got.data,
				exp.data);
			errors++;
		end
	endtask

	task automatic check_flags(input logic [2:0] got, input logic [2:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s ctrl/sop/eop got %b expected %b", $time, what, got,
				exp);
			errors++;
		end
	endtask

	task automatic check_reg(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s reads %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s is %b expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic test_begin();
		tests++;
		test_err0 = errors;
	endtask

	task automatic test_end(input string name);
		if (errors == test_err0) begin
			$display("test %0d %s: pass", tests, name);
		end else begin
			$display("test %0d %s: FAIL, %0d error(s)", tests, name, errors - test_err0);
		end
	endtask

	// APB access, setup at one falling edge and access phase at the next
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int waited;
		@(negedge clk);
		psel_i    = 1'b1;
		penable_i = 1'b0;
		pwrite_i  = wr;
		paddr_i   = addr;
		pwdata_i  = wdata;
		@(negedge clk);
		penable_i = 1'b1;
		#1;
		waited = 0;
		while (!pready_o && waited < WAIT_LIMIT) begin
			@(negedge clk);
			#1;
			waited++;
		end
		if (!pready_o) begin
			report_fail($sformatf("APB access to %h never got pready", addr));
		end
		rdata = prdata_o;
		err   = pslverr_o;
		@(negedge clk);
		psel_i    = 1'b0;
		penable_i = 1'b0;
		pwrite_i  = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
		logic [31:0] unused;
		logic        err;
		apb_xfer(1'b1, addr, wdata, unused, err);
		check_bit(err, 1'b0, $sformatf("pslverr on write to %h", addr));
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata,
		output logic err);
		apb_xfer(1'b0, addr, 32'h0, rdata, err);
	endtask

	task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp,
		input string what);
		logic [31:0] rdata;
		logic        err;
		apb_read(addr, rdata, err);
		check_reg(rdata, exp, what);
		check_bit(err, 1'b0, {"pslverr on ", what});
	endtask

	task automatic set_config(input int bm, input logic [7:0] ch, input logic en);
		apb_write(8'h04, bm);
		apb_write(8'h00, {16'h0, ch, 7'h0, en});
		bmax     = bm;
		chan_cfg = ch;
	endtask

	task automatic push_exp(input ilk_word_u w, input logic [2:0] flags);
		exp_word.push_back(w);
		exp_flags.push_back(flags);
		if (flags[2]) begin
			ctrl_total++;
		end else begin
			data_total++;
		end
	endtask

	// framing model, opening word per burst, closing word after eop
	task automatic add_packet(input int n, input logic [2:0] bytes);
		int          left;
		int          take;
		int          idx;
		int          k;
		logic [63:0] d;
		ilk_word_u   w;
		left = n;
		idx  = 0;
		take = 0;
		while (left > 0) begin
			take             = (left < bmax) ? left : bmax;
			w                = '0;
			w.ctl.ctl_type   = 2'b10;
			w.ctl.sop        = (idx == 0);
			w.ctl.chan       = chan_cfg;
			w.ctl.burst_len  = bmax[7:0];
			push_exp(w, {1'b1, idx == 0, 1'b0});
			for (k = 0; k < take; k++) begin
				d = {rand32(), rand32()};
				stim_data.push_back(d);
				stim_flags.push_back({idx == 0, idx == n - 1});
				stim_bytes.push_back(bytes);
				w.data = d;
				push_exp(w, {1'b0, idx == 0, idx == n - 1});
				idx++;
			end
			left -= take;
		end
		w               = '0;
		w.ctl.ctl_type  = 2'b01;
		w.ctl.eop       = 1'b1;
		w.ctl.eop_bytes = bytes;
		w.ctl.chan      = chan_cfg;
		// closing word carries the length of the last burst
		w.ctl.burst_len = take[7:0];
		push_exp(w, 3'b101);
	endtask

	// input driver, one word per transfer
	task automatic drive_stim();
		int i;
		int waited;
		@(negedge clk);
		for (i = 0; i < stim_data.size(); i++) begin
			in_valid_i     = 1'b1;
			in_data_i      = stim_data[i];
			in_sop_i       = stim_flags[i][1];
			in_eop_i       = stim_flags[i][0];
			in_eop_bytes_i = stim_bytes[i];
			waited = 0;
			while (!in_ready_o && waited < WAIT_LIMIT) begin
				@(negedge clk);
				waited++;
			end
			if (!in_ready_o) begin
				report_fail($sformatf("input word %0d was never accepted", i));
				break;
			end
			// ready seen low phase, transfer happens at the coming rising edge
			@(negedge clk);
		end
		in_valid_i = 1'b0;
	endtask

	// output collector, ready picked per cycle from the LCG
	task automatic collect(input int n, input int bp_pct);
		int idle;
		int k;
		idle = 0;
		while (got_word.size() < n && idle < WAIT_LIMIT) begin
			@(negedge clk);
			out_ready_i = (rand32() % 100) >= bp_pct;
			if (out_valid_o && out_ready_i) begin
				got_word.push_back(out_data_o);
				got_flags.push_back({out_ctrl_o, out_sop_o, out_eop_o});
				idle = 0;
			end else begin
				idle++;
			end
		end
		if (got_word.size() < n) begin
			report_fail($sformatf("output stalled after %0d of %0d words", got_word.size(),
				n));
		end
		// nothing more may come out
		for (k = 0; k < QUIET; k++) begin
			@(negedge clk);
			out_ready_i = 1'b1;
			if (out_valid_o) begin
				report_fail("extra output word after the expected ones");
				break;
			end
		end
	endtask

	task automatic run_traffic(input int bp_pct);
		int i;
		int n;
		n = exp_word.size();
		fork
			drive_stim();
			collect(n, bp_pct);
		join
		if (got_word.size() != n) begin
			report_fail($sformatf("got %0d output words, expected %0d", got_word.size(), n));
		end
		for (i = 0; i < n && i < got_word.size(); i++) begin
			check_word(got_word[i], exp_word[i], $sformatf("output %0d", i));
			check_flags(got_flags[i], exp_flags[i], $sformatf("output %0d", i));
		end
		stim_data.delete();
		stim_flags.delete();
		stim_bytes.delete();
		exp_word.delete();
		exp_flags.delete();
		got_word.delete();
		got_flags.delete();
	endtask

	task automatic test_regs();
		logic [31:0] rdata;
		logic        err;
		test_begin();
		read_expect(8'h00, 32'h0, "CTRL after reset");
		read_expect(8'h04, 32'd16, "BURST after reset");
		read_expect(8'h08, 32'h0, "DCNT after reset");
		read_expect(8'h0C, 32'h0, "CCNT after reset");
		apb_write(8'h00, 32'h0000_A501);
		read_expect(8'h00, 32'h0000_A501, "CTRL readback");
		apb_write(8'h04, 32'h0000_0023);
		read_expect(8'h04, 32'h0000_0023, "BURST readback");
		apb_read(8'h10, rdata, err);
		check_bit(err, 1'b1, "pslverr on unmapped read");
		check_reg(rdata, 32'h0, "unmapped read data");
		test_end("reset and registers");
	endtask

	task automatic test_disabled();
		int k;
		bit ready_seen;
		bit out_seen;
		test_begin();
		set_config(16, 8'h00, 1'b0);
		ready_seen = 0;
		out_seen   = 0;
		@(negedge clk);
		in_valid_i = 1'b1;
		in_data_i  = 64'h0123_4567_89ab_cdef;
		in_sop_i   = 1'b1;
		in_eop_i   = 1'b1;
		for (k = 0; k < WAIT_LIMIT; k++) begin
			@(negedge clk);
			ready_seen |= in_ready_o;
			out_seen   |= out_valid_o;
		end
		in_valid_i = 1'b0;
		if (ready_seen) begin
			report_fail("in_ready_o went high while the path was disabled");
		end
		if (out_seen) begin
			report_fail("an output word appeared while the path was disabled");
		end
		test_end("disabled path");
	endtask

	task automatic test_short();
		test_begin();
		set_config(16, 8'h5A, 1'b1);
		add_packet(3, 3'd5);
		run_traffic(0);
		test_end("single short packet");
	endtask

	task automatic test_long();
		test_begin();
		set_config(16, 8'h5A, 1'b1);
		add_packet(40, 3'd0);
		run_traffic(0);
		test_end("long packet");
	endtask

	task automatic test_backpressure();
		int p;
		test_begin();
		set_config(5, 8'hC3, 1'b1);
		for (p = 0; p < 6; p++) begin
			add_packet(1 + int'(rand32() % 23), 3'(rand32() % 8));
		end
		run_traffic(40);
		test_end("random back-pressure");
	endtask

	task automatic test_counters();
		test_begin();
		read_expect(8'h08, data_total, "DCNT");
		read_expect(8'h0C, ctrl_total, "CCNT");
		// any value written clears both counters
		apb_write(8'h08, 32'hDEAD_BEEF);
		read_expect(8'h08, 32'h0, "DCNT after clear");
		read_expect(8'h0C, 32'h0, "CCNT after clear");
		test_end("counters");
	endtask

	initial begin
		seed           = 32'he02b_6c4d;
		errors         = 0;
		checks         = 0;
		tests          = 0;
		data_total     = 0;
		ctrl_total     = 0;
		bmax           = 16;
		chan_cfg       = 8'h00;
		arst           = 1'b1;
		psel_i         = 1'b0;
		penable_i      = 1'b0;
		pwrite_i       = 1'b0;
		paddr_i        = 8'h00;
		pwdata_i       = 32'h0;
		in_valid_i     = 1'b0;
		in_data_i      = 64'h0;
		in_sop_i       = 1'b0;
		in_eop_i       = 1'b0;
		in_eop_bytes_i = 3'd0;
		out_ready_i    = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		arst = 1'b0;

		test_regs();
		test_disabled();
		test_short();
		test_long();
		test_backpressure();
		test_counters();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- ilk_tx_burst_top.sv
/*
 * Interlaken TX burst path
 * input skid, burst framer, output skid and APB registers on plain ports
 */
`timescale 1ns/10ps

module ilk_tx_burst_top (
	input  logic                              clk,
	input  logic                              arst,
	input  logic                              psel_i,
	input  logic                              penable_i,
	input  logic                              pwrite_i,
	input  logic [ilk_pkg::ILK_APB_AW-1:0]    paddr_i,
	input  logic [ilk_pkg::ILK_APB_DW-1:0]    pwdata_i,
	output logic [ilk_pkg::ILK_APB_DW-1:0]    prdata_o,
	output logic                              pready_o,
	output logic                              pslverr_o,
	input  logic                              in_valid_i,
	output logic                              in_ready_o,
	input  logic [ilk_pkg::ILK_WORD_W-1:0]    in_data_i,
	input  logic                              in_sop_i,
	input  logic                              in_eop_i,
	input  logic [ilk_pkg::ILK_BYTES_W-1:0]   in_eop_bytes_i,
	output logic                              out_valid_o,
	input  logic                              out_ready_i,
	output logic [ilk_pkg::ILK_WORD_W-1:0]    out_data_o,
	output logic                              out_ctrl_o,
	output logic                              out_sop_o,
	output logic                              out_eop_o
);
	import ilk_pkg::*;

	logic                   enable;
	logic [ILK_CHAN_W-1:0]  chan;
	logic [ILK_BURST_W-1:0] burst_max;

	// port side streams
	ilk_stream_if s_port_in ();
	ilk_stream_if s_port_out ();
	// skid_in to framer, framer to skid_out
	ilk_stream_if s_in ();
	ilk_stream_if s_fr ();

	// input ports onto the stream, all input words are data
	assign s_port_in.valid     = in_valid_i;
	assign s_port_in.word      = in_data_i;
	assign s_port_in.ctrl      = 1'b0;
	assign s_port_in.sop       = in_sop_i;
	assign s_port_in.eop       = in_eop_i;
	assign s_port_in.eop_bytes = in_eop_bytes_i;
	assign in_ready_o          = s_port_in.ready;

	// output stream onto the ports, byte count rides in the closing word
	assign out_valid_o      = s_port_out.valid;
	assign out_data_o       = s_port_out.word.data;
	assign out_ctrl_o       = s_port_out.ctrl;
	assign out_sop_o        = s_port_out.sop;
	assign out_eop_o        = s_port_out.eop;
	assign s_port_out.ready = out_ready_i;

	ilk_ready_skid skid_in (
		.clk  (clk),
		.arst (arst),
		.up_i (s_port_in),
		.dn_o (s_in)
	);

	ilk_burst_framer u_framer (
		.clk         (clk),
		.arst        (arst),
		.enable_i    (enable),
		.chan_i      (chan),
		.burst_max_i (burst_max),
		.in_i        (s_in),
		.out_o       (s_fr)
	);

	ilk_ready_skid skid_out (
		.clk  (clk),
		.arst (arst),
		.up_i (s_fr),
		.dn_o (s_port_out)
	);

	ilk_apb_regs u_regs (
		.clk         (clk),
		.arst        (arst),
		.psel_i      (psel_i),
		.penable_i   (penable_i),
		.pwrite_i    (pwrite_i),
		.paddr_i     (paddr_i),
		.pwdata_i    (pwdata_i),
		.prdata_o    (prdata_o),
		.pready_o    (pready_o),
		.pslverr_o   (pslverr_o),
		.out_fire_i  (out_valid_o & out_ready_i),
		.out_ctrl_i  (out_ctrl_o),
		.enable_o    (enable),
		.chan_o      (chan),
		.burst_max_o (burst_max)
	);

endmodule

//--- ilk_apb_regs.sv
/*
 * Interlaken TX register block
 * APB access to enable, channel and burst limit, plus counters of the
 * data and control words leaving the path
 */
`timescale 1ns/10ps

module ilk_apb_regs (
	input  logic                             clk,
	input  logic                             arst,
	input  logic                             psel_i,
	input  logic                             penable_i,
	input  logic                             pwrite_i,
	input  logic [ilk_pkg::ILK_APB_AW-1:0]   paddr_i,
	input  logic [ilk_pkg::ILK_APB_DW-1:0]   pwdata_i,
	output logic [ilk_pkg::ILK_APB_DW-1:0]   prdata_o,
	output logic                             pready_o,
	output logic                             pslverr_o,
	input  logic                             out_fire_i,
	input  logic                             out_ctrl_i,
	output logic                             enable_o,
	output logic [ilk_pkg::ILK_CHAN_W-1:0]   chan_o,
	output logic [ilk_pkg::ILK_BURST_W-1:0]  burst_max_o
);
	import ilk_pkg::*;

	logic                   access;
	logic                   wr;
	logic                   mapped;
	logic                   cnt_clr;
	logic                   en_q;
	logic [ILK_CHAN_W-1:0]  chan_q;
	logic [ILK_BURST_W-1:0] burst_q;
	logic [ILK_APB_DW-1:0]  dcnt_q;
	logic [ILK_APB_DW-1:0]  ccnt_q;

	// access phase of a transfer
	assign access  = psel_i & penable_i;
	assign wr      = access & pwrite_i;
	assign mapped  = (paddr_i == ILK_REG_CTRL) || (paddr_i == ILK_REG_BURST) ||
		(paddr_i == ILK_REG_DCNT) || (paddr_i == ILK_REG_CCNT);
	// either counter address clears both
	assign cnt_clr = wr & ((paddr_i == ILK_REG_DCNT) || (paddr_i == ILK_REG_CCNT));

	// no wait states
	assign pready_o  = 1'b1;
	assign pslverr_o = access & ~mapped;

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			en_q    <= 1'b0;
			chan_q  <= '0;
			burst_q <= ILK_BURST_RST;
		end else if (wr) begin
			if (paddr_i == ILK_REG_CTRL) begin
				en_q   <= pwdata_i[ILK_CTRL_EN_BIT];
				chan_q <= pwdata_i[ILK_CTRL_CHAN_LSB +: ILK_CHAN_W];
			end
			if (paddr_i == ILK_REG_BURST) begin
				burst_q <= pwdata_i[ILK_BURST_W-1:0];
			end
		end
	end

	// output word counters, clear beats a count in the same cycle
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			dcnt_q <= '0;
			ccnt_q <= '0;
		end else if (cnt_clr) begin
			dcnt_q <= '0;
			ccnt_q <= '0;
		end else if (out_fire_i) begin
			if (out_ctrl_i) begin
				ccnt_q <= ccnt_q + 1'b1;
			end else begin
				dcnt_q <= dcnt_q + 1'b1;
			end
		end
	end

	// read mux, unmapped reads give zero
	always_comb begin
		prdata_o = '0;
		case (paddr_i)
			ILK_REG_CTRL: begin
				prdata_o[ILK_CTRL_EN_BIT]                  = en_q;
				prdata_o[ILK_CTRL_CHAN_LSB +: ILK_CHAN_W] = chan_q;
			end
			ILK_REG_BURST: prdata_o[ILK_BURST_W-1:0] = burst_q;
			ILK_REG_DCNT:  prdata_o = dcnt_q;
			ILK_REG_CCNT:  prdata_o = ccnt_q;
			default:       prdata_o = '0;
		endcase
	end

	assign enable_o    = en_q;
	assign chan_o      = chan_q;
	assign burst_max_o = burst_q;

endmodule

//--- ilk_burst_framer.sv
/*
 * Interlaken burst framer
 * splits packets into bursts of up to burst_max words, puts an opening
 * control word ahead of each burst and a closing word after eop
 */
`timescale 1ns/10ps

module ilk_burst_framer (
	input logic                             clk,
	input logic                             arst,
	input logic                             enable_i,
	input logic [ilk_pkg::ILK_CHAN_W-1:0]   chan_i,
	input logic [ilk_pkg::ILK_BURST_W-1:0]  burst_max_i,
	ilk_stream_if.sink                      in_i,
	ilk_stream_if.source                    out_o
);
	import ilk_pkg::*;

	logic [ILK_FSM_W-1:0]   state_q;
	// a packet has started and its closing word is not out yet
	logic                   pkt_q;
	// data words sent in the current burst
	logic [ILK_BURST_W-1:0] cnt_q;
	logic [ILK_BURST_W-1:0] cnt_nxt;
	// burst limit taken when the burst opened
	logic [ILK_BURST_W-1:0] max_q;
	logic [ILK_BYTES_W-1:0] bytes_q;
	ilk_word_u              cw;
	logic                   in_fire;
	logic                   out_fire;

	// wraps to 0 at 256, same coding as the burst length field
	assign cnt_nxt  = cnt_q + 1'b1;
	assign in_fire  = in_i.valid & in_i.ready;
	assign out_fire = out_o.valid & out_o.ready;

	// control word for the current state
	always_comb begin
		cw          = '0;
		cw.ctl.chan = chan_i;
		if (state_q == ILK_ST_CLOSE) begin
			cw.ctl.ctl_type  = ILK_CTL_CLOSE;
			cw.ctl.eop       = 1'b1;
			cw.ctl.eop_bytes = bytes_q;
			// real length of the last burst
			cw.ctl.burst_len = cnt_q;
		end else begin
			cw.ctl.ctl_type  = ILK_CTL_OPEN;
			cw.ctl.sop       = ~pkt_q;
			// remaining length unknown here, announce the limit
			cw.ctl.burst_len = burst_max_i;
		end
	end

	// output mux and input ready
	always_comb begin
		out_o.valid     = 1'b0;
		out_o.word      = cw;
		out_o.ctrl      = 1'b1;
		out_o.sop       = cw.ctl.sop;
		out_o.eop       = cw.ctl.eop;
		out_o.eop_bytes = cw.ctl.eop_bytes;
		in_i.ready      = 1'b0;
		case (state_q)
			ILK_ST_BURST: begin
				out_o.valid     = in_i.valid;
				out_o.word      = in_i.word;
				out_o.ctrl      = in_i.ctrl;
				out_o.sop       = in_i.sop;
				out_o.eop       = in_i.eop;
				out_o.eop_bytes = in_i.eop_bytes;
				in_i.ready      = out_o.ready;
			end
			ILK_ST_CLOSE: begin
				out_o.valid = 1'b1;
			end
			default: begin
				// open only once data waits, a started packet ignores enable
				out_o.valid = in_i.valid & (enable_i | pkt_q);
				// nothing waiting yet, let the input skid take a word
				in_i.ready  = ~in_i.valid & (enable_i | pkt_q);
			end
		endcase
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			state_q <= ILK_ST_IDLE;
			pkt_q   <= 1'b0;
			cnt_q   <= '0;
			max_q   <= ILK_BURST_RST;
		end else begin
			case (state_q)
				ILK_ST_BURST: begin
					if (in_fire) begin
						cnt_q <= cnt_nxt;
						// eop wins over a full burst
						if (in_i.eop) begin
							state_q <= ILK_ST_CLOSE;
						end else if (cnt_nxt == max_q) begin
							state_q <= ILK_ST_IDLE;
						end
					end
				end
				ILK_ST_CLOSE: begin
					if (out_fire) begin
						state_q <= ILK_ST_IDLE;
						pkt_q   <= 1'b0;
					end
				end
				default: begin
					// opening word accepted
					if (out_fire) begin
						state_q <= ILK_ST_BURST;
						pkt_q   <= 1'b1;
						cnt_q   <= '0;
						max_q   <= burst_max_i;
					end
				end
			endcase
		end
	end

	// byte count of the last word, for the closing word
	always_ff @(posedge clk) begin
		if (in_fire && in_i.eop) begin
			bytes_q <= in_i.eop_bytes;
		end
	end

endmodule

//--- ilk_ready_skid.sv
/*
 * Ready/valid skid stage
 * registered ready toward the source, main plus backup word storage
 * so nothing is dropped while the ready change travels upstream
 */
`timescale 1ns/10ps

module ilk_ready_skid (
	input logic        clk,
	input logic        arst,
	ilk_stream_if.sink   up_i,
	ilk_stream_if.source dn_o
);
	import ilk_pkg::*;

	logic [ILK_PAY_W-1:0] up_pay;
	logic [ILK_PAY_W-1:0] main_q;
	logic [ILK_PAY_W-1:0] backup_q;
	logic                 backup_valid_q;

	// output copies drive the ports
	logic                 ready_q;
	logic                 valid_q;
	// twin copies feed the internal decisions, cuts fanout on the port flops
	logic                 ready_dup_q;
	logic                 valid_dup_q;

	logic                 main_leave;
	logic                 up_take;
	logic                 to_main;

	assign up_pay = {up_i.word, up_i.ctrl, up_i.sop, up_i.eop, up_i.eop_bytes};

	assign main_leave = valid_dup_q & dn_o.ready;
	assign up_take    = ready_dup_q & up_i.valid;
	// main slot is free this edge or empties this edge
	assign to_main    = dn_o.ready | ~valid_dup_q;

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			ready_q        <= 1'b0;
			ready_dup_q    <= 1'b0;
			valid_q        <= 1'b0;
			valid_dup_q    <= 1'b0;
			backup_valid_q <= 1'b0;
		end else begin
			ready_q     <= dn_o.ready;
			ready_dup_q <= dn_o.ready;

			if (main_leave) begin
				if (backup_valid_q) begin
					// backup moves up, main stays valid
					backup_valid_q <= 1'b0;
				end else begin
					valid_q     <= 1'b0;
					valid_dup_q <= 1'b0;
				end
			end

			if (up_take) begin
				if (to_main) begin
					valid_q     <= 1'b1;
					valid_dup_q <= 1'b1;
				end else begin
					// stalled output, park the word and hold off the source
					backup_valid_q <= 1'b1;
					ready_q        <= 1'b0;
					ready_dup_q    <= 1'b0;
				end
			end
		end
	end

	// word storage
	always_ff @(posedge clk) begin
		if (main_leave && backup_valid_q) begin
			main_q <= backup_q;
		end
		if (up_take) begin
			if (to_main) begin
				main_q <= up_pay;
			end else begin
				backup_q <= up_pay;
			end
		end
	end

	assign up_i.ready     = ready_q;
	assign dn_o.valid     = valid_q;
	assign dn_o.word      = main_q[ILK_PAY_W-1 -: ILK_WORD_W];
	assign dn_o.ctrl      = main_q[ILK_BYTES_W+2];
	assign dn_o.sop       = main_q[ILK_BYTES_W+1];
	assign dn_o.eop       = main_q[ILK_BYTES_W];
	assign dn_o.eop_bytes = main_q[ILK_BYTES_W-1:0];

endmodule

//--- ilk_stream_if.sv
/*
 * Interlaken stream interface
 * ready/valid word stream with per-word control and packet flags
 */
`timescale 1ns/10ps

interface ilk_stream_if;
	import ilk_pkg::*;

	logic                   valid;
	logic                   ready;
	ilk_word_u              word;
	// high for a burst control word
	logic                   ctrl;
	logic                   sop;
	logic                   eop;
	logic [ILK_BYTES_W-1:0] eop_bytes;

	modport source (
		output valid, word, ctrl, sop, eop, eop_bytes,
		input  ready
	);

	modport sink (
		input  valid, word, ctrl, sop, eop, eop_bytes,
		output ready
	);

endinterface

//--- ilk_pkg.sv
/*
 * Interlaken TX burst package
 * sizes, the data/control word views, state and word-type encodings
 * and the APB register map shared by the transmit burst path
 */
package ilk_pkg;

	// word and field sizes
	localparam int ILK_WORD_W  = 64;
	localparam int ILK_BYTES_W = 3;
	localparam int ILK_CHAN_W  = 8;
	// 0 in a burst length field stands for 256 words
	localparam int ILK_BURST_W = 8;
	localparam int ILK_RSVD_W  = ILK_WORD_W - 2 - 1 - 1 - ILK_BYTES_W - ILK_CHAN_W
		- ILK_BURST_W;

	// skid payload: word, ctrl, sop, eop, eop_bytes
	localparam int ILK_PAY_W = ILK_WORD_W + 3 + ILK_BYTES_W;

	// control word types
	localparam logic [1:0] ILK_CTL_OPEN  = 2'b10;
	localparam logic [1:0] ILK_CTL_CLOSE = 2'b01;

	// framer FSM encoding
	localparam int ILK_FSM_W = 2;
	localparam logic [ILK_FSM_W-1:0] ILK_ST_IDLE  = 2'd0;
	localparam logic [ILK_FSM_W-1:0] ILK_ST_BURST = 2'd1;
	localparam logic [ILK_FSM_W-1:0] ILK_ST_CLOSE = 2'd2;

	// APB bus sizes
	localparam int ILK_APB_AW = 8;
	localparam int ILK_APB_DW = 32;

	// register map
	localparam logic [ILK_APB_AW-1:0] ILK_REG_CTRL  = 8'h00;
	localparam logic [ILK_APB_AW-1:0] ILK_REG_BURST = 8'h04;
	localparam logic [ILK_APB_AW-1:0] ILK_REG_DCNT  = 8'h08;
	localparam logic [ILK_APB_AW-1:0] ILK_REG_CCNT  = 8'h0C;

	// CTRL register layout
	localparam int ILK_CTRL_EN_BIT   = 0;
	localparam int ILK_CTRL_CHAN_LSB = 8;

	// burst length after reset
	localparam logic [ILK_BURST_W-1:0] ILK_BURST_RST = 8'd16;

	// control word view, msb first
	typedef struct packed {
		logic [1:0]             ctl_type;
		logic                   sop;
		logic                   eop;
		logic [ILK_BYTES_W-1:0] eop_bytes;
		logic [ILK_CHAN_W-1:0]  chan;
		logic [ILK_BURST_W-1:0] burst_len;
		// stays zero, no CRC24 on this path
		logic [ILK_RSVD_W-1:0]  reserved;
	} ilk_ctrl_t;

	// one word on the wire, seen as payload or as control
	typedef union packed {
		logic [ILK_WORD_W-1:0] data;
		ilk_ctrl_t             ctl;
	} ilk_word_u;

endpackage
